/* dual_port_frame_agg.f */
verilog/frame_agg_pkg.sv
verilog/async_frame_fifo.sv
verilog/frame_rr_arbiter.sv
verilog/dual_port_frame_agg.sv
sim/dual_port_frame_agg_assertions.sv
sim/tb_dual_port_frame_agg.sv

/* sim/tb_dual_port_frame_agg.sv */
// ##########################################################
// testbench for the two-port frame aggregator: frame table,
// producers, random back-pressure, scoreboard and watchdog
// ##########################################################

`timescale 1ns/1ps

module tb_dual_port_frame_agg;
    import frame_agg_pkg::*;

    typedef struct {
        int         port;
        int         len;
        bit         bad;
        bit         oversize;
        logic [7:0] tail_keep;
    } frame_entry_t;

    localparam int num_entries = 14;

    logic         output_clk = 1'b0;
    logic         in0_clk = 1'b0;
    logic         in1_clk = 1'b0;
    logic         async_rst;
    stream_beat_t in0_beat;
    stream_beat_t in1_beat;
    stream_beat_t out_beat;
    logic         in0_valid;
    logic         in1_valid;
    logic         in0_user;
    logic         in1_user;
    logic         in0_ready;
    logic         in1_ready;
    logic         out_valid;
    logic         out_ready;
    logic [1:0]   good_frame;
    logic [1:0]   bad_frame;
    logic [1:0]   overflow;

    frame_entry_t frames [num_entries];
    bit           committed [num_entries + 1];
    time          commit_time [num_entries + 1];
    time          prev_last_time;
    int           sent_beats [2];
    int           recv_beats [2];
    int           exp_entry [2];
    bit           ready_seen [2];
    int           exp_good [2];
    int           exp_bad [2];
    int           exp_ovf [2];
    int           pulse_good [2];
    int           pulse_bad [2];
    int           pulse_ovf [2];
    int           errors;
    int           out_beats;
    int           exp_beats;
    int           frames_done;
    int           exp_frames;
    int           limit_ns;
    int           cur_port;
    int           cur_entry;
    int           cur_beat;
    int           prev_port;
    bit           in_frame;
    integer       seed;

    always #5 output_clk = ~output_clk;
    always #5 in0_clk = ~in0_clk;
    always #7 in1_clk = ~in1_clk;

    dual_port_frame_agg #(
        .addr_width     (5),
        .drop_when_full (1'b1)
    ) u_dual_port_frame_agg (.*);

    // port, entry and beat index packed into every word
    function automatic stream_data_t make_data(input int port, input int entry, input int beat);
        return {8'h5a, 8'(port), 16'(entry), 16'(beat), (16'(entry * 37 + beat) ^ 16'hc3a5)};
    endfunction

    function automatic int next_good(input int port, input int from);
        for (int i = from; i < num_entries; i++) begin
            if (frames[i].port == port && !frames[i].bad && !frames[i].oversize) begin
                return i;
            end
        end
        return num_entries;
    endfunction

    task automatic in_edge(input int port, input bit rising);
        if (port == 0) begin
            if (rising) @(posedge in0_clk);
            else @(negedge in0_clk);
        end else begin
            if (rising) @(posedge in1_clk);
            else @(negedge in1_clk);
        end
    endtask

    task automatic drive_port(input int port, input stream_beat_t beat, input logic valid,
                              input logic user);
        if (port == 0) begin
            in0_beat  <= beat;
            in0_valid <= valid;
            in0_user  <= user;
        end else begin
            in1_beat  <= beat;
            in1_valid <= valid;
            in1_user  <= user;
        end
    endtask

    // status pulse shows up in the cycle after the last beat
    task automatic check_status(input int idx);
        int         port;
        logic [2:0] got;
        logic [2:0] want;
        port = frames[idx].port;
        got  = {good_frame[port], bad_frame[port], overflow[port]};
        want = frames[idx].oversize ? 3'b001 : (frames[idx].bad ? 3'b010 : 3'b100);
        assert (got == want) else begin
            $display("mismatch at %0t: entry %0d status %b, expected %b", $time, idx, got, want);
            errors++;
        end
        if (want == 3'b100) begin
            committed[idx]   = 1'b1;
            commit_time[idx] = $time;
            sent_beats[port] += frames[idx].len;
        end else if (want == 3'b010) begin
            $display("entry %0d port %0d: bad frame discarded", idx, port);
        end else begin
            $display("entry %0d port %0d: oversize frame of %0d beats dropped", idx, port,
                     frames[idx].len);
        end
    endtask

    // ready stays low in reset, then never falls again since full frames are dropped
    task automatic check_ready(input int port, input logic ready);
        if (async_rst) begin
            assert (ready === 1'b0) else begin
                $display("mismatch at %0t: port %0d ready high during reset", $time, port);
                errors++;
            end
        end else if (ready_seen[port]) begin
            assert (ready === 1'b1) else begin
                $display("mismatch at %0t: port %0d ready fell after reset release", $time,
                         port);
                errors++;
            end
        end
        if (ready === 1'b1) begin
            ready_seen[port] = 1'b1;
        end
    endtask

    task automatic send_frame(input int idx);
        int           port;
        stream_beat_t beat;
        port = frames[idx].port;
        for (int b = 0; b < frames[idx].len; b++) begin
            beat.data = make_data(port, idx, b);
            beat.last = (b == frames[idx].len - 1);
            beat.keep = beat.last ? frames[idx].tail_keep : 8'hff;
            in_edge(port, 1'b1);
            drive_port(port, beat, 1'b1, frames[idx].bad && beat.last);
            in_edge(port, 1'b0);
            while (!(port == 0 ? in0_ready : in1_ready)) begin
                in_edge(port, 1'b0);
            end
        end
        in_edge(port, 1'b1);
        drive_port(port, '0, 1'b0, 1'b0);
        in_edge(port, 1'b0);
        check_status(idx);
    endtask

    // frames that can fit wait for room, keeping slack for pointer sync lag
    task automatic run_port(input int port);
        for (int idx = 0; idx < num_entries; idx++) begin
            if (frames[idx].port == port) begin
                if (!frames[idx].oversize) begin
                    wait (sent_beats[port] - recv_beats[port] + frames[idx].len <= 24);
                end
                send_frame(idx);
            end
        end
    endtask

    task automatic check_beat();
        int           port;
        int           entry;
        int           pend;
        bit           start_ok;
        stream_beat_t exp_beat;
        port  = out_beat.data[55:48];
        entry = out_beat.data[47:32];
        out_beats++;
        if (!in_frame) begin
            start_ok = (port < 2) && (entry == exp_entry[port & 1]);
            assert (start_ok) else begin
                $display("mismatch at %0t: frame starts with port %0d entry %0d", $time, port,
                         entry);
                errors++;
            end
            if (start_ok && prev_port == port) begin
                pend = exp_entry[1 - port];
                // other port had a frame visible before the arbiter went idle
                assert (!(pend < num_entries && committed[pend]
                          && commit_time[pend] + 40 <= prev_last_time)) else begin
                    $display("mismatch at %0t: port %0d served twice while entry %0d waited",
                             $time, port, pend);
                    errors++;
                end
            end
            cur_port  = port & 1;
            cur_entry = (entry < num_entries) ? entry : 0;
            cur_beat  = 0;
            in_frame  = 1'b1;
        end
        assert (port == cur_port && entry == cur_entry) else begin
            $display("mismatch at %0t: beat of port %0d entry %0d inside entry %0d", $time,
                     port, entry, cur_entry);
            errors++;
        end
        exp_beat.last = (cur_beat == frames[cur_entry].len - 1);
        exp_beat.keep = exp_beat.last ? frames[cur_entry].tail_keep : 8'hff;
        exp_beat.data = make_data(cur_port, cur_entry, cur_beat);
        assert (out_beat == exp_beat) else begin
            $display("mismatch at %0t: entry %0d beat %0d got %h expected %h", $time,
                     cur_entry, cur_beat, out_beat, exp_beat);
            errors++;
        end
        cur_beat++;
        recv_beats[cur_port]++;
        if (out_beat.last) begin
            $display("entry %0d port %0d: good frame of %0d beats received", cur_entry,
                     cur_port, cur_beat);
            frames_done++;
            exp_entry[cur_port] = next_good(cur_port, cur_entry + 1);
            prev_port      = cur_port;
            prev_last_time = $time;
            in_frame       = 1'b0;
        end
    endtask

    // consumer back-pressure
    always @(posedge output_clk) begin
        out_ready <= (($random(seed) & 3) != 0);
    end

    always @(negedge output_clk) begin
        if (!async_rst && out_valid && out_ready) begin
            check_beat();
        end
    end

    always @(negedge in0_clk) begin
        pulse_good[0] += good_frame[0];
        pulse_bad[0]  += bad_frame[0];
        pulse_ovf[0]  += overflow[0];
        check_ready(0, in0_ready);
    end

    always @(negedge in1_clk) begin
        pulse_good[1] += good_frame[1];
        pulse_bad[1]  += bad_frame[1];
        pulse_ovf[1]  += overflow[1];
        check_ready(1, in1_ready);
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("timeout: frames still missing after %0d ns", limit_ns);
        $display("Regression failed");
        $finish;
    end

    initial begin
        seed      = 32'h687d60bb;
        async_rst = 1'b1;
        in0_beat  = '0;
        in1_beat  = '0;
        in0_valid = 1'b0;
        in1_valid = 1'b0;
        in0_user  = 1'b0;
        in1_user  = 1'b0;
        out_ready = 1'b0;
        prev_port = -1;
        // port, length, bad, oversize, tail keep
        frames[0]  = '{0, 4, 1'b0, 1'b0, 8'hff};
        frames[1]  = '{1, 6, 1'b0, 1'b0, 8'h0f};
        frames[2]  = '{0, 3, 1'b1, 1'b0, 8'hff};
        frames[3]  = '{1, 2, 1'b0, 1'b0, 8'h01};
        frames[4]  = '{0, 40, 1'b0, 1'b1, 8'hff};
        frames[5]  = '{1, 8, 1'b0, 1'b0, 8'h3f};
        frames[6]  = '{0, 5, 1'b0, 1'b0, 8'h7f};
        frames[7]  = '{1, 36, 1'b0, 1'b1, 8'hff};
        frames[8]  = '{0, 2, 1'b0, 1'b0, 8'h03};
        frames[9]  = '{1, 5, 1'b1, 1'b0, 8'hff};
        frames[10] = '{0, 7, 1'b0, 1'b0, 8'hff};
        frames[11] = '{1, 4, 1'b0, 1'b0, 8'h1f};
        frames[12] = '{0, 6, 1'b0, 1'b0, 8'hff};
        frames[13] = '{1, 3, 1'b0, 1'b0, 8'h07};
        for (int i = 0; i < num_entries; i++) begin
            limit_ns += frames[i].len;
            if (frames[i].oversize) begin
                exp_ovf[frames[i].port]++;
            end else if (frames[i].bad) begin
                exp_bad[frames[i].port]++;
            end else begin
                exp_good[frames[i].port]++;
                exp_beats += frames[i].len;
                exp_frames++;
            end
        end
        limit_ns     = (limit_ns * 40 + 200) * 10;
        exp_entry[0] = next_good(0, 0);
        exp_entry[1] = next_good(1, 0);
        repeat (2) @(posedge output_clk);
        async_rst <= 1'b0;
        fork
            run_port(0);
            run_port(1);
        join
        wait (frames_done >= exp_frames);
        repeat (20) @(posedge output_clk);
        assert (out_beats == exp_beats) else begin
            $display("mismatch at %0t: %0d output beats, expected %0d", $time, out_beats,
                     exp_beats);
            errors++;
        end
        for (int p = 0; p < 2; p++) begin
            assert (pulse_good[p] == exp_good[p] && pulse_bad[p] == exp_bad[p]
                    && pulse_ovf[p] == exp_ovf[p]) else begin
                $display("mismatch at %0t: port %0d pulses good %0d bad %0d overflow %0d",
                         $time, p, pulse_good[p], pulse_bad[p], pulse_ovf[p]);
                errors++;
            end
        end
        $display("%0d entries, %0d of %0d output beats, %0d errors", num_entries, out_beats,
                 exp_beats, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* sim/dual_port_frame_agg_assertions.sv */
// ##########################################################
// concurrent checks on the frame arbiter, attached by bind
// ##########################################################

`timescale 1ns/1ps

module arbiter_checks (
    input logic                        output_clk,
    input logic                        async_rst,
    input frame_agg_pkg::stream_beat_t out_beat,
    input logic                        out_valid,
    input logic                        out_ready,
    input logic                        src0_ready,
    input logic                        src1_ready,
    input frame_agg_pkg::arb_state_t   state
);
    import frame_agg_pkg::*;

    logic frame_end;

    assign frame_end = out_valid && out_ready && out_beat.last;

    // stalled output holds its beat
    assert property (@(posedge output_clk) disable iff (async_rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("output beat changed while out_ready was low");

    assert property (@(posedge output_clk) disable iff (async_rst)
        !(src0_ready && src1_ready))
        else $error("both sources saw ready at once");

    // grant is locked until the last beat leaves
    assert property (@(posedge output_clk) disable iff (async_rst)
        state != arb_idle && !frame_end |=> state == $past(state))
        else $error("grant moved inside a frame");

endmodule

bind frame_rr_arbiter arbiter_checks u_arbiter_checks (
    .output_clk (output_clk),
    .async_rst  (async_rst),
    .out_beat   (out_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .src0_ready (src0_ready),
    .src1_ready (src1_ready),
    .state      (state)
);

/* verilog/dual_port_frame_agg.sv */
// ##########################################################
// two-port AXI4-Stream frame aggregator top level
// ##########################################################

`timescale 1ns/1ps

module dual_port_frame_agg #(
    // log2 of FIFO depth, at least 2
    parameter int addr_width     = 12,
    parameter bit drop_when_full = 1'b0
) (
    input  logic                        async_rst,

    // input port 0
    input  logic                        in0_clk,
    input  frame_agg_pkg::stream_beat_t in0_beat,
    input  logic                        in0_valid,
    output logic                        in0_ready,
    input  logic                        in0_user,

    // input port 1
    input  logic                        in1_clk,
    input  frame_agg_pkg::stream_beat_t in1_beat,
    input  logic                        in1_valid,
    output logic                        in1_ready,
    input  logic                        in1_user,

    // merged output
    input  logic                        output_clk,
    output frame_agg_pkg::stream_beat_t out_beat,
    output logic                        out_valid,
    input  logic                        out_ready,

    // bit n belongs to the clock of input n
    output logic [1:0]                  good_frame,
    output logic [1:0]                  bad_frame,
    output logic [1:0]                  overflow
);
    import frame_agg_pkg::*;

    stream_beat_t fifo0_beat;
    stream_beat_t fifo1_beat;
    logic         fifo0_valid;
    logic         fifo1_valid;
    logic         fifo0_ready;
    logic         fifo1_ready;

    async_frame_fifo #(
        .addr_width     (addr_width),
        .drop_when_full (drop_when_full)
    ) u_fifo0 (
        .async_rst  (async_rst),
        .in_clk     (in0_clk),
        .in_beat    (in0_beat),
        .in_valid   (in0_valid),
        .in_ready   (in0_ready),
        .in_user    (in0_user),
        .output_clk (output_clk),
        .out_beat   (fifo0_beat),
        .out_valid  (fifo0_valid),
        .out_ready  (fifo0_ready),
        .good_frame (good_frame[0]),
        .bad_frame  (bad_frame[0]),
        .overflow   (overflow[0])
    );

    async_frame_fifo #(
        .addr_width     (addr_width),
        .drop_when_full (drop_when_full)
    ) u_fifo1 (
        .async_rst  (async_rst),
        .in_clk     (in1_clk),
        .in_beat    (in1_beat),
        .in_valid   (in1_valid),
        .in_ready   (in1_ready),
        .in_user    (in1_user),
        .output_clk (output_clk),
        .out_beat   (fifo1_beat),
        .out_valid  (fifo1_valid),
        .out_ready  (fifo1_ready),
        .good_frame (good_frame[1]),
        .bad_frame  (bad_frame[1]),
        .overflow   (overflow[1])
    );

    // whole frames from either FIFO onto the output
    frame_rr_arbiter u_arbiter (
        .output_clk (output_clk),
        .async_rst  (async_rst),
        .src0_beat  (fifo0_beat),
        .src0_valid (fifo0_valid),
        .src0_ready (fifo0_ready),
        .src1_beat  (fifo1_beat),
        .src1_valid (fifo1_valid),
        .src1_ready (fifo1_ready),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

/* verilog/frame_rr_arbiter.sv */
// ##########################################################
// round-robin frame arbiter, two sources onto one stream
// ##########################################################

`timescale 1ns/1ps

module frame_rr_arbiter (
    input  logic                        output_clk,
    input  logic                        async_rst,

    // source 0
    input  frame_agg_pkg::stream_beat_t src0_beat,
    input  logic                        src0_valid,
    output logic                        src0_ready,

    // source 1
    input  frame_agg_pkg::stream_beat_t src1_beat,
    input  logic                        src1_valid,
    output logic                        src1_ready,

    // merged output
    output frame_agg_pkg::stream_beat_t out_beat,
    output logic                        out_valid,
    input  logic                        out_ready
);
    import frame_agg_pkg::*;

    arb_state_t state;
    arb_state_t state_next;

    // port that finished the most recent frame
    logic last_port;
    logic last_port_next;
    logic frame_end;

    // pass the granted source straight through
    always_comb begin
        out_beat   = src0_beat;
        out_valid  = 1'b0;
        src0_ready = 1'b0;
        src1_ready = 1'b0;
        case (state)
            arb_port0: begin
                out_beat   = src0_beat;
                out_valid  = src0_valid;
                src0_ready = out_ready;
            end
            arb_port1: begin
                out_beat   = src1_beat;
                out_valid  = src1_valid;
                src1_ready = out_ready;
            end
            default: begin
                out_beat = src0_beat;
            end
        endcase
    end

    assign frame_end = out_valid && out_ready && out_beat.last;

    always_comb begin
        state_next     = state;
        last_port_next = last_port;
        case (state)
            arb_idle: begin
                if (src0_valid && src1_valid) begin
                    // both waiting, the other port goes next
                    state_next = last_port ? arb_port0 : arb_port1;
                end else if (src0_valid) begin
                    state_next = arb_port0;
                end else if (src1_valid) begin
                    state_next = arb_port1;
                end
            end
            arb_port0: begin
                if (frame_end) begin
                    state_next     = arb_idle;
                    last_port_next = 1'b0;
                end
            end
            arb_port1: begin
                if (frame_end) begin
                    state_next     = arb_idle;
                    last_port_next = 1'b1;
                end
            end
            default: begin
                state_next = arb_idle;
            end
        endcase
    end

    // last_port starts at 1 so port 0 wins the first tie
    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            state     <= arb_idle;
            last_port <= 1'b1;
        end else begin
            state     <= state_next;
            last_port <= last_port_next;
        end
    end

endmodule

/* verilog/async_frame_fifo.sv */
// ##########################################################
// dual-clock AXI4-Stream frame FIFO with Gray pointer sync
// drops bad frames and frames that do not fit
// ##########################################################

`timescale 1ns/1ps

module async_frame_fifo #(
    parameter int addr_width     = 12,
    parameter bit drop_when_full = 1'b0
) (
    input  logic                        async_rst,

    // write side
    input  logic                        in_clk,
    input  frame_agg_pkg::stream_beat_t in_beat,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic                        in_user,

    // read side
    input  logic                        output_clk,
    output frame_agg_pkg::stream_beat_t out_beat,
    output logic                        out_valid,
    input  logic                        out_ready,

    // per-frame status, one in_clk pulse each
    output logic                        good_frame,
    output logic                        bad_frame,
    output logic                        overflow
);
    import frame_agg_pkg::*;

    // one extra bit tells full from empty
    typedef logic [addr_width:0] ptr_t;

    localparam ptr_t fifo_depth = ptr_t'(1) << addr_width;

    function automatic ptr_t bin_to_gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic ptr_t gray_to_bin(input ptr_t gray);
        ptr_t bin;
        bin[addr_width] = gray[addr_width];
        for (int i = addr_width - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    stream_beat_t mem [0:(1 << addr_width) - 1];

    logic [2:0] in_rst_sync;
    logic [2:0] out_rst_sync;
    logic       in_rst;
    logic       out_rst;

    // write domain pointers
    ptr_t wr_ptr;
    ptr_t wr_ptr_cur;
    ptr_t wr_ptr_inc;
    ptr_t wr_ptr_gray;
    ptr_t rd_ptr_gray_sync1;
    ptr_t rd_ptr_gray_sync2;
    ptr_t rd_ptr_sync_bin;

    // read domain pointers
    ptr_t rd_ptr;
    ptr_t rd_ptr_inc;
    ptr_t rd_ptr_gray;
    ptr_t wr_ptr_gray_sync1;
    ptr_t wr_ptr_gray_sync2;

    logic drop_frame;
    logic full;
    logic frame_full;
    logic empty;
    logic write;
    logic mem_write;
    logic read;

    assign in_rst  = in_rst_sync[2];
    assign out_rst = out_rst_sync[2];

    // write side stays in reset while the read side is still held
    always_ff @(posedge in_clk or posedge async_rst) begin
        if (async_rst) begin
            in_rst_sync <= 3'b111;
        end else begin
            in_rst_sync <= {in_rst_sync[1], in_rst_sync[0] | out_rst_sync[0], 1'b0};
        end
    end

    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            out_rst_sync <= 3'b111;
        end else begin
            out_rst_sync <= {out_rst_sync[1:0], 1'b0};
        end
    end

    assign wr_ptr_inc      = wr_ptr_cur + 1'b1;
    assign rd_ptr_sync_bin = gray_to_bin(rd_ptr_gray_sync2);

    // speculative fill against the reader, and size of the open frame
    assign full       = (ptr_t'(wr_ptr_cur - rd_ptr_sync_bin) == fifo_depth);
    assign frame_full = (ptr_t'(wr_ptr_cur - wr_ptr) == fifo_depth);

    // a frame larger than the FIFO must be swallowed even without drop_when_full
    assign in_ready  = !in_rst && (drop_when_full || !full || frame_full || drop_frame);
    assign write     = in_valid && in_ready;
    assign mem_write = write && !full && !drop_frame;

    always_ff @(posedge in_clk) begin
        if (mem_write) begin
            mem[wr_ptr_cur[addr_width-1:0]] <= in_beat;
        end
    end

    always_ff @(posedge in_clk or posedge in_rst) begin
        if (in_rst) begin
            wr_ptr      <= '0;
            wr_ptr_cur  <= '0;
            wr_ptr_gray <= '0;
            drop_frame  <= 1'b0;
            good_frame  <= 1'b0;
            bad_frame   <= 1'b0;
            overflow    <= 1'b0;
        end else begin
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;
            if (write) begin
                if (full || drop_frame) begin
                    // no room, discard the rest of this frame
                    drop_frame <= 1'b1;
                    if (in_beat.last) begin
                        wr_ptr_cur <= wr_ptr;
                        drop_frame <= 1'b0;
                        overflow   <= 1'b1;
                    end
                end else begin
                    wr_ptr_cur <= wr_ptr_inc;
                    if (in_beat.last) begin
                        if (in_user) begin
                            // rewind over the bad frame
                            wr_ptr_cur <= wr_ptr;
                            bad_frame  <= 1'b1;
                        end else begin
                            // publish the whole frame at once
                            wr_ptr      <= wr_ptr_inc;
                            wr_ptr_gray <= bin_to_gray(wr_ptr_inc);
                            good_frame  <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // read pointer into the write domain
    always_ff @(posedge in_clk or posedge in_rst) begin
        if (in_rst) begin
            rd_ptr_gray_sync1 <= '0;
            rd_ptr_gray_sync2 <= '0;
        end else begin
            rd_ptr_gray_sync1 <= rd_ptr_gray;
            rd_ptr_gray_sync2 <= rd_ptr_gray_sync1;
        end
    end

    // committed write pointer into the read domain
    always_ff @(posedge output_clk or posedge out_rst) begin
        if (out_rst) begin
            wr_ptr_gray_sync1 <= '0;
            wr_ptr_gray_sync2 <= '0;
        end else begin
            wr_ptr_gray_sync1 <= wr_ptr_gray;
            wr_ptr_gray_sync2 <= wr_ptr_gray_sync1;
        end
    end

    assign empty      = (rd_ptr_gray == wr_ptr_gray_sync2);
    assign read       = (out_ready || !out_valid) && !empty;
    assign rd_ptr_inc = rd_ptr + 1'b1;

    always_ff @(posedge output_clk or posedge out_rst) begin
        if (out_rst) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
            out_valid   <= 1'b0;
        end else begin
            if (read) begin
                rd_ptr      <= rd_ptr_inc;
                rd_ptr_gray <= bin_to_gray(rd_ptr_inc);
            end
            // output register holds while stalled
            if (out_ready || !out_valid) begin
                out_valid <= !empty;
            end
        end
    end

    always_ff @(posedge output_clk) begin
        if (read) begin
            out_beat <= mem[rd_ptr[addr_width-1:0]];
        end
    end

endmodule

/* verilog/frame_agg_pkg.sv */
// ##########################################################
// stream widths, beat struct and arbiter state encoding
// shared by the dual port frame aggregator
// ##########################################################

package frame_agg_pkg;

    // stream width is fixed for the whole subsystem
    localparam int data_width = 64;

    // one byte enable per data byte
    localparam int keep_width = data_width / 8;

    typedef logic [data_width-1:0] stream_data_t;

    typedef logic [keep_width-1:0] stream_keep_t;

    // one FIFO memory word
    // last sits on top so a flat view reads {last, keep, data}
    typedef struct packed {
        logic         last;
        stream_keep_t keep;
        stream_data_t data;
    } stream_beat_t;

    // frame arbiter states
    // idle locks a port, the port states pass one whole frame
    typedef enum logic [1:0] {
        arb_idle  = 2'd0,
        arb_port0 = 2'd1,
        arb_port1 = 2'd2
    } arb_state_t;

endpackage
